// File: verilog/mipsPkg.sv
package mipsPkg;

    //////////////////////////////////////////////////
    // instruction word, three views of the same bits
    //////////////////////////////////////////////////
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rFmt;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iFmt;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] index;
        } jFmt;
    } instrWord;

    // opcodes
    localparam logic [5:0] opR      = 6'b000000;
    localparam logic [5:0] opRegImm = 6'b000001;   // bltz / bgez, rt selects
    localparam logic [5:0] opJ      = 6'b000010;
    localparam logic [5:0] opJal    = 6'b000011;
    localparam logic [5:0] opBeq    = 6'b000100;
    localparam logic [5:0] opBne    = 6'b000101;
    localparam logic [5:0] opBlez   = 6'b000110;
    localparam logic [5:0] opBgtz   = 6'b000111;
    localparam logic [5:0] opAddi   = 6'b001000;
    localparam logic [5:0] opSlti   = 6'b001010;
    localparam logic [5:0] opAndi   = 6'b001100;
    localparam logic [5:0] opOri    = 6'b001101;
    localparam logic [5:0] opXori   = 6'b001110;
    localparam logic [5:0] opLb     = 6'b100000;
    localparam logic [5:0] opLh     = 6'b100001;
    localparam logic [5:0] opLw     = 6'b100011;
    localparam logic [5:0] opSb     = 6'b101000;
    localparam logic [5:0] opSh     = 6'b101001;
    localparam logic [5:0] opSw     = 6'b101011;

    // rt field under opRegImm
    localparam logic [4:0] rtBltz = 5'b00000;
    localparam logic [4:0] rtBgez = 5'b00001;

    // funct codes for opR
    localparam logic [5:0] fnSll  = 6'b000000;
    localparam logic [5:0] fnSrl  = 6'b000010;
    localparam logic [5:0] fnJr   = 6'b001000;
    localparam logic [5:0] fnMult = 6'b011000;
    localparam logic [5:0] fnAdd  = 6'b100000;
    localparam logic [5:0] fnSub  = 6'b100010;
    localparam logic [5:0] fnAnd  = 6'b100100;
    localparam logic [5:0] fnOr   = 6'b100101;
    localparam logic [5:0] fnXor  = 6'b100110;
    localparam logic [5:0] fnNor  = 6'b100111;
    localparam logic [5:0] fnSlt  = 6'b101010;

    //////////////////////////////////////////////////
    // ALU codes
    //////////////////////////////////////////////////
    localparam logic [4:0] aluAdd = 5'b00001;
    localparam logic [4:0] aluSub = 5'b00010;
    localparam logic [4:0] aluMul = 5'b00011;
    localparam logic [4:0] aluSll = 5'b00100;
    localparam logic [4:0] aluSrl = 5'b00101;
    localparam logic [4:0] aluAnd = 5'b00110;
    localparam logic [4:0] aluOr  = 5'b00111;
    localparam logic [4:0] aluXor = 5'b01000;
    localparam logic [4:0] aluNor = 5'b01101;
    localparam logic [4:0] aluSlt = 5'b01110;
    localparam logic [4:0] aluEq  = 5'b01100;      // branch conditions from here
    localparam logic [4:0] aluNe  = 5'b01111;
    localparam logic [4:0] aluGtz = 5'b10000;
    localparam logic [4:0] aluLez = 5'b10001;
    localparam logic [4:0] aluGez = 5'b10010;
    localparam logic [4:0] aluLtz = 5'b10011;

    // access sizes, same for load and store
    localparam logic [1:0] accNone = 2'b00;
    localparam logic [1:0] accWord = 2'b01;
    localparam logic [1:0] accHalf = 2'b10;
    localparam logic [1:0] accByte = 2'b11;

    localparam logic [4:0] regRa = 5'd31;          // jal link register

endpackage

// File: verilog/controller.sv
`timescale 1ns/100ps

module controller (
    input  logic              arstN,
    input  mipsPkg::instrWord instr,
    output logic              regWrite,
    output logic              aluSrc,
    output logic              regDst,
    output logic              memToReg,
    output logic              branch,
    output logic              jump,
    output logic              jr,
    output logic              jal,
    output logic              shiftSel,
    output logic [4:0]        aluCode,
    output logic [1:0]        loadSize,
    output logic [1:0]        storeSize
);

    always_comb begin
        // everything inactive unless a case below turns it on
        regWrite  = 1'b0;
        aluSrc    = 1'b0;
        regDst    = 1'b0;
        memToReg  = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        jr        = 1'b0;
        jal       = 1'b0;
        shiftSel  = 1'b0;
        aluCode   = mipsPkg::aluAdd;
        loadSize  = mipsPkg::accNone;
        storeSize = mipsPkg::accNone;

        case (instr.rFmt.opcode)
            //////////////////////////////////////////////////
            // R-type
            //////////////////////////////////////////////////
            mipsPkg::opR: begin
                regWrite = 1'b1;
                regDst   = 1'b1;
                memToReg = 1'b1;                        // alu result
                case (instr.rFmt.funct)
                    mipsPkg::fnSll: begin
                        aluCode  = mipsPkg::aluSll;
                        shiftSel = 1'b1;                // amount from shamt
                    end
                    mipsPkg::fnSrl: begin
                        aluCode  = mipsPkg::aluSrl;
                        shiftSel = 1'b1;
                    end
                    mipsPkg::fnAdd:  aluCode = mipsPkg::aluAdd;
                    mipsPkg::fnSub:  aluCode = mipsPkg::aluSub;
                    mipsPkg::fnMult: aluCode = mipsPkg::aluMul;   // low word only
                    mipsPkg::fnAnd:  aluCode = mipsPkg::aluAnd;
                    mipsPkg::fnOr:   aluCode = mipsPkg::aluOr;
                    mipsPkg::fnXor:  aluCode = mipsPkg::aluXor;
                    mipsPkg::fnNor:  aluCode = mipsPkg::aluNor;
                    mipsPkg::fnSlt:  aluCode = mipsPkg::aluSlt;
                    mipsPkg::fnJr: begin
                        regWrite = 1'b0;
                        jr       = 1'b1;
                    end
                    default: regWrite = 1'b0;           // unknown funct, no-op
                endcase
            end

            //////////////////////////////////////////////////
            // loads and stores, address is rs + imm
            //////////////////////////////////////////////////
            mipsPkg::opLw, mipsPkg::opLh, mipsPkg::opLb: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                case (instr.iFmt.opcode)
                    mipsPkg::opLw: loadSize = mipsPkg::accWord;
                    mipsPkg::opLh: loadSize = mipsPkg::accHalf;
                    default:       loadSize = mipsPkg::accByte;
                endcase
            end
            mipsPkg::opSw, mipsPkg::opSh, mipsPkg::opSb: begin
                aluSrc = 1'b1;
                case (instr.iFmt.opcode)
                    mipsPkg::opSw: storeSize = mipsPkg::accWord;
                    mipsPkg::opSh: storeSize = mipsPkg::accHalf;
                    default:       storeSize = mipsPkg::accByte;
                endcase
            end

            // immediates; logic codes make mipsCore zero-extend the imm
            mipsPkg::opAddi, mipsPkg::opSlti, mipsPkg::opAndi,
            mipsPkg::opOri, mipsPkg::opXori: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                memToReg = 1'b1;
                case (instr.iFmt.opcode)
                    mipsPkg::opSlti: aluCode = mipsPkg::aluSlt;
                    mipsPkg::opAndi: aluCode = mipsPkg::aluAnd;
                    mipsPkg::opOri:  aluCode = mipsPkg::aluOr;
                    mipsPkg::opXori: aluCode = mipsPkg::aluXor;
                    default:         aluCode = mipsPkg::aluAdd;
                endcase
            end

            //////////////////////////////////////////////////
            // branches and jumps
            //////////////////////////////////////////////////
            mipsPkg::opBeq: begin
                branch  = 1'b1;
                aluCode = mipsPkg::aluEq;
            end
            mipsPkg::opBne: begin
                branch  = 1'b1;
                aluCode = mipsPkg::aluNe;
            end
            mipsPkg::opBgtz: begin
                branch  = 1'b1;
                aluCode = mipsPkg::aluGtz;
            end
            mipsPkg::opBlez: begin
                branch  = 1'b1;
                aluCode = mipsPkg::aluLez;
            end
            mipsPkg::opRegImm: begin
                // rt extends the opcode here
                if (instr.iFmt.rt == mipsPkg::rtBgez) begin
                    branch  = 1'b1;
                    aluCode = mipsPkg::aluGez;
                end else if (instr.iFmt.rt == mipsPkg::rtBltz) begin
                    branch  = 1'b1;
                    aluCode = mipsPkg::aluLtz;
                end
            end
            mipsPkg::opJ: jump = 1'b1;
            mipsPkg::opJal: begin
                jump     = 1'b1;
                jal      = 1'b1;
                regWrite = 1'b1;                        // link into ra
            end
            default: ;                                  // no-op
        endcase

        if (!arstN) begin                               // quiet while in reset
            regWrite  = 1'b0;
            branch    = 1'b0;
            jump      = 1'b0;
            jr        = 1'b0;
            jal       = 1'b0;
            storeSize = mipsPkg::accNone;
        end
    end

endmodule

// File: verilog/aluUnit.sv
`timescale 1ns/100ps

module aluUnit (
    input  logic [4:0]  aluCode,
    input  logic [31:0] opA,
    input  logic [31:0] opB,
    input  logic [4:0]  shamt,
    input  logic        shiftSel,
    output logic [31:0] result,
    output logic        branchTaken
);

    logic [4:0] shiftAmt;
    logic       isNeg;
    logic       isZero;

    assign shiftAmt = shiftSel ? shamt : opA[4:0];  // shamt field or rs
    assign isNeg    = opA[31];
    assign isZero   = (opA == 32'd0);

    //////////////////////////////////////////////////
    // data operations
    //////////////////////////////////////////////////
    always_comb begin
        case (aluCode)
            mipsPkg::aluAdd: result = opA + opB;
            mipsPkg::aluSub: result = opA - opB;
            mipsPkg::aluMul: result = opA * opB;        // low 32 bits
            mipsPkg::aluSll: result = opB << shiftAmt;
            mipsPkg::aluSrl: result = opB >> shiftAmt;
            mipsPkg::aluAnd: result = opA & opB;
            mipsPkg::aluOr:  result = opA | opB;
            mipsPkg::aluXor: result = opA ^ opB;
            mipsPkg::aluNor: result = ~(opA | opB);
            mipsPkg::aluSlt: result = {31'd0, $signed(opA) < $signed(opB)};
            default:         result = 32'd0;
        endcase
    end

    //////////////////////////////////////////////////
    // branch conditions
    //////////////////////////////////////////////////
    always_comb begin
        case (aluCode)
            mipsPkg::aluEq:  branchTaken = (opA == opB);
            mipsPkg::aluNe:  branchTaken = (opA != opB);
            mipsPkg::aluGez: branchTaken = !isNeg;
            mipsPkg::aluLtz: branchTaken = isNeg;
            mipsPkg::aluGtz: branchTaken = !isNeg && !isZero;
            mipsPkg::aluLez: branchTaken = isNeg || isZero;
            default:         branchTaken = 1'b0;    // data ops never branch
        endcase
    end

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/100ps

module registerFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    input  logic [4:0]  wrAddr,
    input  logic        wrEn,
    input  logic [31:0] wrData,
    output logic [31:0] rsData,
    output logic [31:0] rtData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wrEn && wrAddr != 5'd0) begin  // r0 never written
            regs[wrAddr] <= wrData;
        end
    end

    // asynchronous reads, r0 forced to zero
    assign rsData = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
    assign rtData = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

endmodule

// File: verilog/loadStoreUnit.sv
`timescale 1ns/100ps

module loadStoreUnit (
    input  logic [31:0] addr,
    input  logic [31:0] storeData,
    input  logic [1:0]  loadSize,
    input  logic [1:0]  storeSize,
    input  logic [31:0] rdWord,
    output logic [31:0] memAddr,
    output logic [3:0]  byteEn,
    output logic [31:0] wrData,
    output logic [31:0] loadData
);

    logic [7:0]  laneByte;
    logic [15:0] laneHalf;

    assign memAddr = {addr[31:2], 2'b00};

    //////////////////////////////////////////////////
    // store side, little-endian lanes
    //////////////////////////////////////////////////
    always_comb begin
        case (storeSize)
            mipsPkg::accWord: begin
                byteEn = 4'b1111;
                wrData = storeData;
            end
            mipsPkg::accHalf: begin
                byteEn = addr[1] ? 4'b1100 : 4'b0011;
                wrData = {2{storeData[15:0]}};      // same half in both lanes
            end
            mipsPkg::accByte: begin
                byteEn = 4'b0001 << addr[1:0];
                wrData = {4{storeData[7:0]}};
            end
            default: begin
                byteEn = 4'b0000;
                wrData = storeData;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // load side
    //////////////////////////////////////////////////
    assign laneByte = rdWord[8*addr[1:0] +: 8];
    assign laneHalf = addr[1] ? rdWord[31:16] : rdWord[15:0];

    always_comb begin
        case (loadSize)
            mipsPkg::accHalf: loadData = {{16{laneHalf[15]}}, laneHalf};
            mipsPkg::accByte: loadData = {{24{laneByte[7]}}, laneByte};
            default:          loadData = rdWord;    // word or no load
        endcase
    end

endmodule

// File: verilog/pcUnit.sv
`timescale 1ns/100ps

module pcUnit (
    input  logic        clk,
    input  logic        arstN,
    input  logic        branch,
    input  logic        jump,
    input  logic        jr,
    input  logic        branchTaken,
    input  logic [15:0] imm,
    input  logic [25:0] index,
    input  logic [31:0] jrTarget,
    output logic [31:0] pc,
    output logic [31:0] pcPlus4
);

    logic [31:0] branchOffset;
    logic [31:0] pcNext;

    assign pcPlus4      = pc + 32'd4;
    assign branchOffset = {{14{imm[15]}}, imm, 2'b00};  // word offset to bytes

    // jr first, then j/jal, then a taken branch
    always_comb begin
        if (jr) begin
            pcNext = jrTarget;
        end else if (jump) begin
            pcNext = {pcPlus4[31:28], index, 2'b00};
        end else if (branch && branchTaken) begin
            pcNext = pcPlus4 + branchOffset;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= 32'd0;
        end else begin
            pc <= pcNext;                           // one instruction per edge
        end
    end

endmodule

// File: verilog/mipsCore.sv
`timescale 1ns/100ps

module mipsCore (
    input  logic        clk,
    input  logic        arstN,
    output logic [31:0] instrAddr,
    input  logic [31:0] instr,
    output logic [31:0] memAddr,
    output logic [3:0]  memByteEn,
    output logic [31:0] memWrData,
    input  logic [31:0] memRdData
);

    mipsPkg::instrWord instrU;

    logic        regWrite, aluSrc, regDst, memToReg;
    logic        branch, jump, jr, jal, shiftSel;
    logic [4:0]  aluCode;
    logic [1:0]  loadSize, storeSize;
    logic [31:0] rsData, rtData;
    logic [31:0] aluResult, loadData, pcPlus4;
    logic        branchTaken;
    logic        zeroExt;
    logic [31:0] immExt;
    logic [31:0] opB;
    logic [4:0]  wrAddr;
    logic [31:0] wrData;

    assign instrU = instr;

    controller controller_inst (
        .arstN(arstN), .instr(instrU),
        .regWrite(regWrite), .aluSrc(aluSrc), .regDst(regDst), .memToReg(memToReg),
        .branch(branch), .jump(jump), .jr(jr), .jal(jal), .shiftSel(shiftSel),
        .aluCode(aluCode), .loadSize(loadSize), .storeSize(storeSize)
    );

    //////////////////////////////////////////////////
    // datapath selection
    //////////////////////////////////////////////////
    // andi/ori/xori take the immediate zero-extended
    assign zeroExt = aluSrc && (aluCode == mipsPkg::aluAnd || aluCode == mipsPkg::aluOr ||
                                aluCode == mipsPkg::aluXor);
    assign immExt  = zeroExt ? {16'd0, instrU.iFmt.imm}
                             : {{16{instrU.iFmt.imm[15]}}, instrU.iFmt.imm};
    assign opB     = aluSrc ? immExt : rtData;

    assign wrAddr = regDst ? instrU.rFmt.rd : (jal ? mipsPkg::regRa : instrU.iFmt.rt);
    assign wrData = jal ? pcPlus4 :
                    (!memToReg && loadSize != mipsPkg::accNone) ? loadData : aluResult;

    registerFile registerFile_inst (
        .clk(clk), .arstN(arstN),
        .rsAddr(instrU.rFmt.rs), .rtAddr(instrU.rFmt.rt), .wrAddr(wrAddr),
        .wrEn(regWrite), .wrData(wrData), .rsData(rsData), .rtData(rtData)
    );

    aluUnit aluUnit_inst (
        .aluCode(aluCode), .opA(rsData), .opB(opB), .shamt(instrU.rFmt.shamt),
        .shiftSel(shiftSel), .result(aluResult), .branchTaken(branchTaken)
    );

    loadStoreUnit loadStoreUnit_inst (
        .addr(aluResult), .storeData(rtData), .loadSize(loadSize), .storeSize(storeSize),
        .rdWord(memRdData), .memAddr(memAddr), .byteEn(memByteEn), .wrData(memWrData),
        .loadData(loadData)
    );

    pcUnit pcUnit_inst (
        .clk(clk), .arstN(arstN),
        .branch(branch), .jump(jump), .jr(jr), .branchTaken(branchTaken),
        .imm(instrU.iFmt.imm), .index(instrU.jFmt.index), .jrTarget(rsData),
        .pc(instrAddr), .pcPlus4(pcPlus4)
    );

endmodule

// File: sim/mipsCoreTb.sv
`timescale 1ns/100ps

module mipsCoreTb;

    logic        clk;
    logic        arstN;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    logic [31:0] memAddr;
    logic [3:0]  memByteEn;
    logic [31:0] memWrData;
    logic [31:0] memRdData;

    logic [31:0] imem [128];
    logic [31:0] dmem [256];

    // expected store table filled once before reset
    string       expName  [64];
    logic [31:0] expAddr  [64];
    logic [3:0]  expEn    [64];
    logic [31:0] expValue [64];
    logic [31:0] expPc    [64];
    logic [5:0]  numStores;
    logic [5:0]  storeIdx;

    logic [31:0] curAddr;
    logic [3:0]  curEn;
    logic [31:0] curValue;
    logic [31:0] curPc;
    logic        storeSeen;
    logic        tableStore;

    mipsCore mipsCore_inst (
        .clk(clk), .arstN(arstN),
        .instrAddr(instrAddr), .instr(instr),
        .memAddr(memAddr), .memByteEn(memByteEn), .memWrData(memWrData),
        .memRdData(memRdData)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // memory models
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        #1;
        instr = imem[instrAddr[8:2]];
        #1;
        memRdData = dmem[memAddr[9:2]];             // after the new fetch settled
    end

    always @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (memByteEn[lane]) begin
                dmem[memAddr[9:2]][8*lane +: 8] <= memWrData[8*lane +: 8];
            end
        end
    end

    always @(posedge clk) begin
        if (storeSeen) begin
            storeIdx <= storeIdx + 6'd1;
        end
    end

    assign storeSeen  = (memByteEn != 4'b0000);
    assign tableStore = storeSeen && (storeIdx < numStores);
    assign curAddr    = expAddr[storeIdx];
    assign curEn      = expEn[storeIdx];
    assign curValue   = expValue[storeIdx];
    assign curPc      = expPc[storeIdx];

    task automatic abortRun(input string why);
        $display("Error: %s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic showMismatch(input string testName, input string field,
                                input logic [31:0] expected, input logic [31:0] actual);
        $display("** Error: %s %s expected %h actual %h", testName, field, expected, actual);
        $display("tests failed");
        $fatal(1);
    endtask

    // little-endian lane pick then sign extension
    function automatic logic [31:0] extendLane(input logic [31:0] word, input logic [1:0] offs,
                                               input int bytes);
        logic [7:0]  lane8;
        logic [15:0] lane16;
        lane8  = word[8*offs +: 8];
        lane16 = offs[1] ? word[31:16] : word[15:0];
        if (bytes == 1) begin
            return {{24{lane8[7]}}, lane8};
        end else if (bytes == 2) begin
            return {{16{lane16[15]}}, lane16};
        end
        return word;
    endfunction

    task automatic addStore(input string name, input logic [31:0] addr, input logic [3:0] en,
                            input logic [31:0] value, input logic [31:0] pc);
        expName[numStores]  = name;
        expAddr[numStores]  = addr;
        expEn[numStores]    = en;
        expValue[numStores] = value;
        expPc[numStores]    = pc;
        numStores = numStores + 6'd1;
    endtask

    task automatic buildTable();
        logic [31:0] arithValues [14];
        logic [31:0] loadAddr [5];
        int          loadBytes [5];
        // add sub mult and or xor nor slt slti andi xori sll srl then r0
        arithValues = '{32'h00007FFE, 32'hFFFF7FF4, 32'hFFFC7FDD, 32'h00008001,
                        32'hFFFFFFFD, 32'hFFFF7FFC, 32'h00000002, 32'h00000001,
                        32'h00000001, 32'h0000F0F0, 32'hFFFFFF06, 32'h00080050,
                        32'h00FFFFFF, 32'h00000000};
        loadAddr    = '{32'h200, 32'h206, 32'h208, 32'h20D, 32'h213};
        loadBytes   = '{4, 2, 2, 1, 1};
        numStores   = 6'd0;
        for (int k = 0; k < 14; k++) begin
            addStore("arithmetic", 32'h100 + 4*k, 4'hF, arithValues[k], 32'h14 + 8*k);
        end
        for (int k = 0; k < 4; k++) begin               // sb at each lane of 0x140
            addStore("subWordStore", 32'h140, 4'b0001 << k, 32'hF9F9F9F9, 32'h80 + 4*k);
        end
        addStore("subWordStore", 32'h148, 4'b0011, 32'h80058005, 32'h90);
        addStore("subWordStore", 32'h148, 4'b1100, 32'h80058005, 32'h94);
        for (int k = 0; k < 5; k++) begin               // load words are never stored to
            addStore("signExtLoad", 32'h150 + 4*k, 4'hF,
                     extendLane(dmem[loadAddr[k][9:2]], loadAddr[k][1:0], loadBytes[k]),
                     32'h9C + 8*k);
        end
        for (int k = 0; k < 6; k++) begin               // one marker per branch kind
            addStore("controlFlow", 32'h164 + 4*k, 4'hF, 32'h00008005, 32'hCC + 16*k);
        end
        addStore("controlFlow", 32'h17C, 4'hF, 32'h00000124, 32'h124);   // jal at 0x120
    endtask

    task automatic waitForEnd(output logic looped);
        logic [31:0] prevAddr;
        int          cycles;
        looped   = 1'b0;
        cycles   = 0;
        prevAddr = instrAddr;
        while (!looped && cycles < 500) begin
            @(posedge clk);
            looped   = (instrAddr == prevAddr);     // jump to itself
            prevAddr = instrAddr;
            cycles++;
        end
    endtask

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    resetQuietEn: assert property (@(posedge clk) !arstN |-> memByteEn == 4'b0000)
        else showMismatch("resetQuiet", "byte enables", 32'd0, {28'd0, $sampled(memByteEn)});
    resetQuietPc: assert property (@(posedge clk) !arstN |-> instrAddr == 32'd0)
        else showMismatch("resetQuiet", "fetch address", 32'd0, $sampled(instrAddr));

    storeCount: assert property (@(posedge clk) disable iff (!arstN)
            storeSeen |-> storeIdx < numStores)
        else abortRun("a store happened after the last expected store");
    storeAddr: assert property (@(posedge clk) disable iff (!arstN)
            tableStore |-> memAddr == curAddr)
        else showMismatch(expName[$sampled(storeIdx)], "address",
                          $sampled(curAddr), $sampled(memAddr));
    storeEn: assert property (@(posedge clk) disable iff (!arstN)
            tableStore |-> memByteEn == curEn)
        else showMismatch(expName[$sampled(storeIdx)], "byte enables",
                          {28'd0, $sampled(curEn)}, {28'd0, $sampled(memByteEn)});
    storeData: assert property (@(posedge clk) disable iff (!arstN)
            tableStore |-> memWrData == curValue)
        else showMismatch(expName[$sampled(storeIdx)], "store data",
                          $sampled(curValue), $sampled(memWrData));
    storePc: assert property (@(posedge clk) disable iff (!arstN)
            tableStore |-> instrAddr == curPc)
        else showMismatch(expName[$sampled(storeIdx)], "fetch address",
                          $sampled(curPc), $sampled(instrAddr));

    initial begin
        logic        looped;
        logic [31:0] firstWord;
        clk       = 1'b0;
        arstN     = 1'b0;
        instr     = 32'd0;
        memRdData = 32'd0;
        storeIdx  = 6'd0;
        $readmemh("sim/program.hex", imem, 0, 76);
        void'($urandom(47));
        for (int i = 0; i < 256; i++) begin
            dmem[i] = $urandom;
        end
        buildTable();
        firstWord = imem[0];
        imem[0]   = 32'hAC000000;                       // sw $0,0($0) fetched during reset
        instr     = imem[0];

        repeat (16) @(posedge clk);
        imem[0] = firstWord;                            // real program from here on
        #1 arstN = 1'b1;

        @(posedge clk);                                 // fetches 0 and then 4 after release
        assert (instrAddr == 32'd0)
            else showMismatch("resetQuiet", "first fetch address", 32'd0, instrAddr);
        @(posedge clk);
        assert (instrAddr == 32'd4)
            else showMismatch("resetQuiet", "second fetch address", 32'd4, instrAddr);

        waitForEnd(looped);
        if (looped && storeIdx == numStores) begin
            $display("all tests passed");
            $finish;
        end else if (!looped) begin
            abortRun("timeout, the program never reached its final jump to itself");
        end else begin
            abortRun($sformatf("the program ended after %0d of %0d expected stores",
                               storeIdx, numStores));
        end
    end

endmodule

// File: sim/program.hex
// instruction words from address 0, two per line, assembly after each pair
// $1 = store base 0x100, $2 = load base 0x200, $3 = -7, $4 = 0x8005
20010100 20020200  // addi $1,$0,0x100 ; addi $2,$0,0x200
2003FFF9 34048005  // addi $3,$0,-7 ; ori $4,$0,0x8005
00642820 AC250000  // add $5,$3,$4 ; sw $5,0($1)
00642822 AC250004  // sub $5,$3,$4 ; sw $5,4($1)
00642818 AC250008  // mult $5,$3,$4 ; sw $5,8($1)
00642824 AC25000C  // and $5,$3,$4 ; sw $5,12($1)
00642825 AC250010  // or $5,$3,$4 ; sw $5,16($1)
00642826 AC250014  // xor $5,$3,$4 ; sw $5,20($1)
00642827 AC250018  // nor $5,$3,$4 ; sw $5,24($1)
0064282A AC25001C  // slt $5,$3,$4 ; sw $5,28($1)
2865FFFA AC250020  // slti $5,$3,-6 ; sw $5,32($1)
3065F0F0 AC250024  // andi $5,$3,0xF0F0 ; sw $5,36($1)
386500FF AC250028  // xori $5,$3,0xFF ; sw $5,40($1)
00042900 AC25002C  // sll $5,$4,4 ; sw $5,44($1)
00032A02 AC250030  // srl $5,$3,8 ; sw $5,48($1)
20000055 AC200034  // addi $0,$0,0x55 ; sw $0,52($1)
A0230040 A0230041  // sb $3,64($1) ; sb $3,65($1)
A0230042 A0230043  // sb $3,66($1) ; sb $3,67($1)
A4240048 A424004A  // sh $4,72($1) ; sh $4,74($1)
8C460000 AC260050  // lw $6,0($2) ; sw $6,80($1)
84460006 AC260054  // lh $6,6($2) ; sw $6,84($1)
84460008 AC260058  // lh $6,8($2) ; sw $6,88($1)
8046000D AC26005C  // lb $6,13($2) ; sw $6,92($1)
80460013 AC260060  // lb $6,19($2) ; sw $6,96($1)
10640001 10840001  // beq $3,$4,+1 not taken ; beq $4,$4,+1 taken
AC230000 AC240064  // skipped sw ; sw $4,100($1)
14840001 14640001  // bne $4,$4,+1 not taken ; bne $3,$4,+1 taken
AC230000 AC240068  // skipped sw ; sw $4,104($1)
04610001 04010001  // bgez $3,+1 not taken ; bgez $0,+1 taken
AC230000 AC24006C  // skipped sw ; sw $4,108($1)
04800001 04600001  // bltz $4,+1 not taken ; bltz $3,+1 taken
AC230000 AC240070  // skipped sw ; sw $4,112($1)
1C000001 1C800001  // bgtz $0,+1 not taken ; bgtz $4,+1 taken
AC230000 AC240074  // skipped sw ; sw $4,116($1)
18800001 18600001  // blez $4,+1 not taken ; blez $3,+1 taken
AC230000 AC240078  // skipped sw ; sw $4,120($1)
0C00004B AC3F007C  // jal 0x12C ; sw $31,124($1)
0800004C 03E00008  // j 0x130 ; jr $31 at 0x12C
0800004C           // j 0x130, final loop

// File: vlog.f
verilog/mipsPkg.sv
verilog/controller.sv
verilog/aluUnit.sv
verilog/registerFile.sv
verilog/loadStoreUnit.sv
verilog/pcUnit.sv
verilog/mipsCore.sv
sim/mipsCoreTb.sv
